// ==== Makefile ====
# Verilator build and run for the DRAM controller testbench

VERILATOR ?= verilator
TOP       ?= dram_ctrl_tb
TRACE     ?= tests/dram_trace.txt
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-GTRACE_FILE='"$(TRACE)"' --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+logic
logic/dram_pkg.sv
logic/bus_pkg.sv
logic/edge_det.sv
logic/data_transfer.sv
logic/control_unit.sv
logic/dram_ctrl_top.sv
tests/dram_ctrl_sva.sv
tests/dram_ctrl_tb.sv

// ==== logic/bus_pkg.sv ====
`include "dram_defs.svh"

package bus_pkg;

    // word address, row bits above column bits
    typedef logic [`DRAM_ROW_W+`DRAM_COL_W-1:0] wb_adr_t;
    typedef logic [`DRAM_DQ_W-1:0] wb_dat_t;

    // one access at a time, ACK also covers the error ending
    typedef enum logic [2:0] {
        IDLE,
        ACT_WAIT,
        WRITE,
        READ,
        PRE_WAIT,
        ACK
    } cu_state_e;

endpackage

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps
`include "dram_defs.svh"

module control_unit (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  bus_pkg::wb_adr_t     wb_adr,
    input  bus_pkg::wb_dat_t     wb_dat_w,
    output bus_pkg::wb_dat_t     wb_dat_r,
    output logic                 wb_ack,
    output logic                 wb_err,
    output dram_pkg::dram_cmd_e  dram_cmd,
    output dram_pkg::row_t       dram_addr,
    output logic                 wr_en,
    output logic                 rd_en,
    output logic                 clear,
    output dram_pkg::beat_idx_t  col_sel,
    output dram_pkg::dq_word_t   wr_word,
    input  dram_pkg::dq_word_t   rd_word,
    input  logic                 burst_done,
    input  logic                 rd_timeout
);
    localparam int BEAT_W = $clog2(`DRAM_BL);
    localparam int WAIT_MAX = (`DRAM_T_RCD > `DRAM_T_RP) ? `DRAM_T_RCD : `DRAM_T_RP;
    localparam int WAIT_W = $clog2(WAIT_MAX + 1);

    bus_pkg::cu_state_e state;
    logic [WAIT_W-1:0]  wait_cnt;
    logic               err_q;
    logic               wb_req;
    bus_pkg::wb_adr_t   adr_q;
    logic               we_q;
    dram_pkg::row_t     row_q;
    dram_pkg::col_t     col_base;

    assign wb_req   = wb_cyc && wb_stb;
    assign row_q    = adr_q[`DRAM_COL_W +: `DRAM_ROW_W];
    // burst starts at the aligned column, the low bits pick the beat
    assign col_base = {adr_q[`DRAM_COL_W-1:BEAT_W], {BEAT_W{1'b0}}};
    assign col_sel  = dram_pkg::beat_idx_t'(adr_q[BEAT_W-1:0]);

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            state     <= bus_pkg::IDLE;
            wait_cnt  <= '0;
            err_q     <= 1'b0;
            dram_cmd  <= dram_pkg::NOP;
            dram_addr <= '0;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
            clear     <= 1'b0;
        end else begin
            // commands and clear are single-cycle
            dram_cmd <= dram_pkg::NOP;
            clear    <= 1'b0;
            case (state)
                bus_pkg::IDLE: begin
                    if (wb_req) begin
                        dram_cmd  <= dram_pkg::ACT;
                        dram_addr <= wb_adr[`DRAM_COL_W +: `DRAM_ROW_W];
                        clear     <= 1'b1;
                        err_q     <= 1'b0;
                        wait_cnt  <= WAIT_W'(`DRAM_T_RCD - 1);
                        state     <= bus_pkg::ACT_WAIT;
                    end
                end
                bus_pkg::ACT_WAIT: begin
                    if (wait_cnt == '0) begin
                        dram_addr <= dram_pkg::row_t'(col_base);
                        if (we_q) begin
                            dram_cmd <= dram_pkg::WR;
                            wr_en    <= 1'b1;
                            state    <= bus_pkg::WRITE;
                        end else begin
                            dram_cmd <= dram_pkg::RD;
                            rd_en    <= 1'b1;
                            state    <= bus_pkg::READ;
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                bus_pkg::WRITE, bus_pkg::READ: begin
                    // timeout still closes the row before reporting
                    if (burst_done || rd_timeout) begin
                        wr_en     <= 1'b0;
                        rd_en     <= 1'b0;
                        err_q     <= rd_timeout;
                        dram_cmd  <= dram_pkg::PRE;
                        dram_addr <= row_q;
                        wait_cnt  <= WAIT_W'(`DRAM_T_RP);
                        state     <= bus_pkg::PRE_WAIT;
                    end
                end
                bus_pkg::PRE_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= bus_pkg::ACK;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                bus_pkg::ACK: begin
                    state <= bus_pkg::IDLE;
                end
                default: begin
                    state <= bus_pkg::IDLE;
                end
            endcase
        end
    end

    // request payload held for the whole access
    always_ff @(posedge CLKx2) begin
        if ((state == bus_pkg::IDLE) && wb_req) begin
            adr_q   <= wb_adr;
            we_q    <= wb_we;
            wr_word <= wb_dat_w;
        end
        if ((state == bus_pkg::READ) && burst_done) begin
            wb_dat_r <= rd_word;
        end
    end

    assign wb_ack = (state == bus_pkg::ACK) && !err_q;
    assign wb_err = (state == bus_pkg::ACK) && err_q;

endmodule

// ==== logic/data_transfer.sv ====
`timescale 1ns/1ps
`include "dram_defs.svh"

module data_transfer (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  logic                 wr_en,
    input  logic                 rd_en,
    input  logic                 clear,
    input  dram_pkg::beat_idx_t  col_sel,
    input  dram_pkg::dq_word_t   wr_word,
    input  dram_pkg::dq_word_t   dq_in,
    input  logic                 dqs_in,
    output dram_pkg::dq_word_t   dq_out,
    output logic                 dq_oe,
    output logic                 dqs_t_out,
    output logic                 dqs_c_out,
    output logic                 dm_n,
    output dram_pkg::dq_word_t   rd_word,
    output logic                 burst_done,
    output logic                 rd_timeout
);
    localparam int BEAT_W = $clog2(`DRAM_BL);
    localparam int TMO_W  = $clog2(`DRAM_RD_BEATS_TIMEOUT + 1);

    // write count: 0..1 preamble, 2..BL+1 beats, BL+2 postamble
    localparam dram_pkg::beat_idx_t WR_FIRST = dram_pkg::beat_idx_t'(2);
    localparam dram_pkg::beat_idx_t WR_POST  = dram_pkg::beat_idx_t'(`DRAM_BL + 2);
    localparam dram_pkg::beat_idx_t RD_LAST  = dram_pkg::beat_idx_t'(`DRAM_BL);

    dram_pkg::beat_idx_t cnt;
    dram_pkg::beat_idx_t beat_num;
    logic [TMO_W-1:0]    tmo_cnt;
    logic                beat_act;
    logic                edge_flag;
    logic                rd_all;
    dram_pkg::dq_word_t  dq_d1;
    dram_pkg::dq_word_t  dq_d2;
    dram_pkg::dq_word_t  word_reg [`DRAM_BL];

    // each DQS edge carries a beat, so catch both
    edge_det #(
        .TRIG_RISE (1'b1),
        .TRIG_FALL (1'b1)
    ) u_edge_det (
        .CLKx2     (CLKx2),
        .nRST      (nRST),
        .async_in  (dqs_in),
        .edge_flag (edge_flag)
    );

    // burst counter steps every cycle on writes, once per strobe edge on reads
    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            cnt     <= '0;
            tmo_cnt <= '0;
        end else if (clear) begin
            cnt     <= '0;
            tmo_cnt <= '0;
        end else begin
            if (wr_en || (rd_en && edge_flag && !rd_all)) begin
                cnt <= cnt + 1'b1;
            end
            if (rd_en && !rd_all) begin
                tmo_cnt <= tmo_cnt + 1'b1;
            end
        end
    end

    // write side
    assign beat_act = wr_en && (cnt >= WR_FIRST) && (cnt < WR_POST);
    assign beat_num = cnt - WR_FIRST;

    assign dq_oe  = wr_en;
    assign dq_out = beat_act ? wr_word : '0;

    // strobe falls on beat 0, then one edge per beat, back high for postamble
    assign dqs_t_out = beat_act ? cnt[0] : 1'b1;
    assign dqs_c_out = ~dqs_t_out;

    // only the addressed column is left unmasked
    assign dm_n = beat_act && (beat_num == col_sel);

    // read side
    // data goes through two flops to match the strobe synchronizer
    always_ff @(posedge CLKx2) begin
        dq_d1 <= dq_in;
        dq_d2 <= dq_d1;
        if (rd_en && edge_flag && !rd_all) begin
            word_reg[cnt[BEAT_W-1:0]] <= dq_d2;
        end
    end

    assign rd_all  = (cnt == RD_LAST);
    assign rd_word = word_reg[col_sel[BEAT_W-1:0]];

    // done pulses in the postamble cycle or right after the eighth capture
    assign burst_done = (wr_en && (cnt == WR_POST)) || (rd_en && rd_all);

    assign rd_timeout = rd_en && !rd_all &&
                        (tmo_cnt == TMO_W'(`DRAM_RD_BEATS_TIMEOUT - 1));

endmodule

// ==== logic/dram_ctrl_top.sv ====
`timescale 1ns/1ps

module dram_ctrl_top (
    input  logic                 CLKx2,
    input  logic                 nRST,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  bus_pkg::wb_adr_t     wb_adr,
    input  bus_pkg::wb_dat_t     wb_dat_w,
    output bus_pkg::wb_dat_t     wb_dat_r,
    output logic                 wb_ack,
    output logic                 wb_err,
    output dram_pkg::dram_cmd_e  dram_cmd,
    output dram_pkg::row_t       dram_addr,
    output dram_pkg::dq_word_t   dq_out,
    output logic                 dq_oe,
    output logic                 dqs_t_out,
    output logic                 dqs_c_out,
    output logic                 dm_n,
    input  dram_pkg::dq_word_t   dq_in,
    input  logic                 dqs_in
);
    // control unit to data path
    logic                wr_en;
    logic                rd_en;
    logic                clear;
    dram_pkg::beat_idx_t col_sel;
    dram_pkg::dq_word_t  wr_word;
    // data path back to control
    dram_pkg::dq_word_t  rd_word;
    logic                burst_done;
    logic                rd_timeout;

    control_unit u_control_unit (
        .CLKx2      (CLKx2),
        .nRST       (nRST),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err),
        .dram_cmd   (dram_cmd),
        .dram_addr  (dram_addr),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .clear      (clear),
        .col_sel    (col_sel),
        .wr_word    (wr_word),
        .rd_word    (rd_word),
        .burst_done (burst_done),
        .rd_timeout (rd_timeout)
    );

    data_transfer u_data_transfer (
        .CLKx2      (CLKx2),
        .nRST       (nRST),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .clear      (clear),
        .col_sel    (col_sel),
        .wr_word    (wr_word),
        .dq_in      (dq_in),
        .dqs_in     (dqs_in),
        .dq_out     (dq_out),
        .dq_oe      (dq_oe),
        .dqs_t_out  (dqs_t_out),
        .dqs_c_out  (dqs_c_out),
        .dm_n       (dm_n),
        .rd_word    (rd_word),
        .burst_done (burst_done),
        .rd_timeout (rd_timeout)
    );

endmodule

// ==== logic/dram_defs.svh ====
`ifndef DRAM_DEFS_SVH
`define DRAM_DEFS_SVH

// data path
`define DRAM_DQ_W 32
`define DRAM_BL 8

// address split, row sits above column on the bus side
`define DRAM_ROW_W 12
`define DRAM_COL_W 10

// command spacing in CLKx2 cycles
`define DRAM_T_RCD 3
`define DRAM_T_RP 3

// read gives up if the strobe stalls this long
`define DRAM_RD_BEATS_TIMEOUT 64

`endif

// ==== logic/dram_pkg.sv ====
`include "dram_defs.svh"

package dram_pkg;

    // one beat on DQ
    typedef logic [`DRAM_DQ_W-1:0] dq_word_t;

    // beat index, one bit spare to count past the burst
    typedef logic [3:0] beat_idx_t;

    typedef logic [`DRAM_ROW_W-1:0] row_t;
    typedef logic [`DRAM_COL_W-1:0] col_t;

    // command bus encoding
    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        RD  = 3'd2,
        WR  = 3'd3,
        PRE = 3'd4
    } dram_cmd_e;

endpackage

// ==== logic/edge_det.sv ====
`timescale 1ns/1ps

module edge_det #(
    parameter bit TRIG_RISE = 1'b1,
    parameter bit TRIG_FALL = 1'b0
) (
    input  logic CLKx2,
    input  logic nRST,
    input  logic async_in,
    output logic edge_flag
);
    logic sync_q1;
    logic sync_q2;
    logic prev_q;

    // strobe idles high, so start the chain high to avoid a false fall
    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
            prev_q  <= 1'b1;
        end else begin
            sync_q1 <= async_in;
            sync_q2 <= sync_q1;
            prev_q  <= sync_q2;
        end
    end

    // one-cycle flag per selected edge
    assign edge_flag = (TRIG_RISE && sync_q2 && !prev_q) ||
                       (TRIG_FALL && !sync_q2 && prev_q);

endmodule

// ==== tests/dram_ctrl_sva.sv ====
`timescale 1ns/1ps

module dram_ctrl_sva (
    input logic                CLKx2,
    input logic                nRST,
    input logic                wb_ack,
    input logic                rd_en,
    input logic                dq_oe,
    input logic                dqs_t_out,
    input logic                dqs_c_out,
    input logic                dm_n,
    input dram_pkg::dram_cmd_e dram_cmd
);
    // failures seen so far, read by the testbench at the end
    int   fail_cnt;
    // row opened by ACT, closed again by PRE
    logic row_open;

    always_ff @(posedge CLKx2 or negedge nRST) begin
        if (!nRST) begin
            row_open <= 1'b0;
        end else if (dram_cmd == dram_pkg::ACT) begin
            row_open <= 1'b1;
        end else if (dram_cmd == dram_pkg::PRE) begin
            row_open <= 1'b0;
        end
    end

    ack_one_cycle: assert property (@(posedge CLKx2) disable iff (!nRST)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack stayed high for more than one cycle");
            fail_cnt++;
        end

    no_drive_on_read: assert property (@(posedge CLKx2) disable iff (!nRST)
        rd_en |-> !dq_oe)
        else begin
            $error("dq_oe high during a read burst");
            fail_cnt++;
        end

    // the unmasked beat sits on a strobe edge of a complementary pair
    dqs_pair: assert property (@(posedge CLKx2) disable iff (!nRST)
        dm_n |-> (dqs_c_out != dqs_t_out) && (dqs_t_out != $past(dqs_t_out)))
        else begin
            $error("unmasked beat without a strobe edge on a complementary DQS pair");
            fail_cnt++;
        end

    act_first: assert property (@(posedge CLKx2) disable iff (!nRST)
        (dram_cmd == dram_pkg::RD || dram_cmd == dram_pkg::WR) |-> row_open)
        else begin
            $error("RD or WR issued without an open row");
            fail_cnt++;
        end

endmodule

// ==== tests/dram_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "dram_defs.svh"

module dram_ctrl_tb;
    parameter string TRACE_FILE = "tests/dram_trace.txt";

    localparam int ACK_TIMEOUT = 200;
    // stb to ack for a write: ACT, tRCD, burst with pre/postamble, PRE, tRP
    localparam int WR_LATENCY = 1 + `DRAM_T_RCD + `DRAM_BL + 3 + 1 + `DRAM_T_RP;
    localparam int BURST_W = `DRAM_BL * `DRAM_DQ_W;

    bit                  CLKx2;
    logic                nRST;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    bus_pkg::wb_adr_t    wb_adr;
    bus_pkg::wb_dat_t    wb_dat_w;
    bus_pkg::wb_dat_t    wb_dat_r;
    logic                wb_ack;
    logic                wb_err;
    dram_pkg::dram_cmd_e dram_cmd;
    dram_pkg::row_t      dram_addr;
    dram_pkg::dq_word_t  dq_out;
    logic                dq_oe;
    logic                dqs_t_out;
    logic                dqs_c_out;
    logic                dm_n;
    dram_pkg::dq_word_t  dq_in = '0;
    logic                dqs_in = 1'b1;

    // DRAM model, one entry per eight-beat burst keyed by row and column base
    logic [BURST_W-1:0]  mem [bus_pkg::wb_adr_t];
    dram_pkg::row_t      open_row;
    bus_pkg::wb_adr_t    burst_key;
    int                  wr_cnt;
    int                  rd_reqs;
    int                  rd_served;
    int                  rd_left;
    bit                  rd_phase;
    bit                  strobe_off;

    int                  checks;
    int                  value_errs;
    int                  timeouts;
    int                  other_errs;

    always #2 CLKx2 = ~CLKx2;

    dram_ctrl_top dut0 (.*);

    bind dram_ctrl_top dram_ctrl_sva sva0 (.*);

    // untouched memory reads back its own word address
    function automatic logic [BURST_W-1:0] fill_burst(input bus_pkg::wb_adr_t key);
        logic [BURST_W-1:0] b;
        int                 i;
        for (i = 0; i < `DRAM_BL; i++) begin
            b[i*`DRAM_DQ_W +: `DRAM_DQ_W] = 32'ha500_0000 | 32'(key) | i;
        end
        return b;
    endfunction

    // model command and write side, sampled mid-cycle
    always @(negedge CLKx2) begin
        logic [BURST_W-1:0] burst;
        if (dram_cmd == dram_pkg::ACT) begin
            open_row = dram_addr;
        end
        if (dram_cmd == dram_pkg::WR || dram_cmd == dram_pkg::RD) begin
            burst_key = {open_row, dram_addr[`DRAM_COL_W-1:0]};
            if (!mem.exists(burst_key)) begin
                mem[burst_key] = fill_burst(burst_key);
            end
        end
        if (dram_cmd == dram_pkg::RD) begin
            rd_reqs++;
        end
        // two preamble cycles after WR, then one beat per cycle
        if (dram_cmd == dram_pkg::WR) begin
            wr_cnt = 0;
        end else if (dq_oe) begin
            wr_cnt++;
        end
        if (dq_oe && dm_n) begin
            burst = mem[burst_key];
            burst[(wr_cnt-2)*`DRAM_DQ_W +: `DRAM_DQ_W] = dq_out;
            mem[burst_key] = burst;
        end
    end

    // model read answer, a strobe edge every two cycles with one beat each
    always @(posedge CLKx2) begin
        logic [BURST_W-1:0] burst;
        if (rd_served != rd_reqs) begin
            rd_served = rd_reqs;
            rd_left   = strobe_off ? 0 : `DRAM_BL;
            rd_phase  = 1'b0;
        end
        if (rd_left > 0) begin
            if (!rd_phase) begin
                burst = mem[burst_key];
                dqs_in <= ~dqs_in;
                dq_in  <= burst[(`DRAM_BL-rd_left)*`DRAM_DQ_W +: `DRAM_DQ_W];
                rd_left--;
            end
            rd_phase = ~rd_phase;
        end
    end

    // skips comments and blank space, then reads op, address and data
    task automatic read_entry(input int fd, output bit ok, output byte op,
                              output bus_pkg::wb_adr_t adr, output bus_pkg::wb_dat_t dat);
        int c;
        ok = 1'b0;
        c = $fgetc(fd);
        while (c == "#" || c == " " || c == "\n" || c == "\r") begin
            if (c == "#") begin
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end
            c = $fgetc(fd);
        end
        if (c != -1) begin
            op = byte'(c);
            ok = ($fscanf(fd, "%h %h", adr, dat) == 2);
        end
    endtask

    // one Wishbone classic access, held until ack or err
    task automatic run_access(input bit we, input bus_pkg::wb_adr_t adr,
                              input bus_pkg::wb_dat_t dat, output bit got_ack,
                              output bit got_err, output bus_pkg::wb_dat_t rdata,
                              output int cycles);
        int n;
        n = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        @(posedge CLKx2);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        while (!got_ack && !got_err && n < ACK_TIMEOUT) begin
            @(negedge CLKx2);
            n++;
            got_ack = wb_ack;
            got_err = wb_err;
        end
        rdata = wb_dat_r;
        // first negedge is still in the cycle where stb goes up
        cycles = n - 1;
        @(posedge CLKx2);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            value_errs++;
            $display("Error %s %s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    initial begin
        int               fd;
        int               idx;
        int               cycles;
        bit               ok;
        bit               got_ack;
        bit               got_err;
        byte              op;
        bus_pkg::wb_adr_t adr;
        bus_pkg::wb_dat_t dat;
        bus_pkg::wb_dat_t rdata;
        string            name;

        nRST     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(32'he336_3886));
        repeat (8) @(posedge CLKx2);
        nRST <= 1'b1;
        @(negedge CLKx2);
        checks++;
        assert (!wb_ack && !wb_err && !dq_oe && !dm_n && dqs_t_out) else begin
            other_errs++;
            $display("DUT outputs are not idle after reset");
        end

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open trace file %s", TRACE_FILE);
        end else begin
            idx = 0;
            read_entry(fd, ok, op, adr, dat);
            while (ok && timeouts == 0) begin
                name = $sformatf("%c %06h (entry %0d)", op, adr, idx);
                strobe_off = (op == "T");
                run_access(op == "W", adr, dat, got_ack, got_err, rdata, cycles);
                if (!got_ack && !got_err) begin
                    timeouts++;
                    $display("%s got neither ack nor err in %0d cycles", name, ACK_TIMEOUT);
                end else if (op == "W") begin
                    check_value(name, "ack", 1, got_ack);
                    check_value(name, "latency", WR_LATENCY, cycles);
                end else if (op == "R") begin
                    check_value(name, "ack", 1, got_ack);
                    check_value(name, "dat_r", dat, rdata);
                end else if (op == "T") begin
                    check_value(name, "err", 1, got_err);
                    check_value(name, "ack", 0, got_ack);
                end else begin
                    other_errs++;
                    $display("%s has an unknown operation", name);
                end
                idx++;
                repeat ($urandom_range(3)) @(posedge CLKx2);
                read_entry(fd, ok, op, adr, dat);
            end
            $fclose(fd);
        end

        $display("checks %0d, value errors %0d, timeouts %0d, other errors %0d, sva %0d",
                 checks, value_errs, timeouts, other_errs, dut0.sva0.fail_cnt);
        if (value_errs + timeouts + other_errs + dut0.sva0.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/dram_trace.txt ====
# op adr data: W writes data, R reads and expects data, T reads with the strobe held
# adr is the 22-bit word address in hex (row above column), data is 32-bit hex
W 000010 deadbeef
R 000010 deadbeef
W 003a45 12345678
R 003a45 12345678
W 000121 11112222
W 000123 33334444
W 000126 55556666
R 000120 a5000120
R 000121 11112222
R 000122 a5000122
R 000123 33334444
R 000124 a5000124
R 000125 a5000125
R 000126 55556666
R 000127 a5000127
T 000200 00000000
W 3ff000 cafef00d
R 3ff000 cafef00d
R 000010 deadbeef
